// File: source/fpm_op_pkg.sv
package fpm_op_pkg;

	localparam int OP_W = 2;

	// floating operation codes, in decoder order af, sf, mf, df
	typedef enum logic [OP_W-1:0] {
		OP_AF = 2'd0,
		OP_SF = 2'd1,
		OP_MF = 2'd2,
		OP_DF = 2'd3
	} fpm_op_t;

	// af and sf need exponent alignment
	function automatic logic is_add_class(input fpm_op_t op);
		logic r;
		r = (op == OP_AF) || (op == OP_SF);
		return r;
	endfunction

	// b enters the adder complemented for everything but mf
	function automatic logic b_compl(input fpm_op_t op);
		logic r;
		r = (op != OP_MF);
		return r;
	endfunction

endpackage

// File: source/fpm_num_pkg.sv
package fpm_num_pkg;

	// exponent as seen on the operand bus
	localparam int EXP_W = 8;

	// two guard bits on top of the exponent, like the L bus
	localparam int EXT_W = 10;

	// representable exponent range
	localparam int signed EXP_MAX = 127;
	localparam int signed EXP_MIN = -128;

	// smaller operand is gone past this shift
	localparam int FAR_SHIFT = 40;
	localparam int SHIFT_W = 6;

	// condition flags
	typedef struct packed {
		logic c;
		logic v;
		logic m;
		logic z;
	} fpm_flags_t;

	// interrupt code
	typedef enum logic [1:0] {
		INT_NONE = 2'd0,
		INT_OVF  = 2'd1,
		INT_UNF  = 2'd2,
		INT_DIV0 = 2'd3
	} fpm_int_t;

endpackage

// File: source/fpm_if.sv
interface exp_status_if import fpm_num_pkg::*;;

	logic signed [EXT_W-1:0] ext_exp;
	logic a_ge_b;
	logic [SHIFT_W-1:0] shift;
	logic far;
	logic ovf;
	logic unf;

	modport src (
		output ext_exp, a_ge_b, shift, far, ovf, unf
	);

	modport dst (
		input ext_exp, a_ge_b, shift, far, ovf, unf
	);

endinterface

interface sgn_status_if;

	logic sgn_prod;
	logic sgn_a;
	logic sgn_b_eff;
	logic res_zero_mul;
	logic res_zero_add;
	logic div0;

	modport src (
		output sgn_prod, sgn_a, sgn_b_eff, res_zero_mul, res_zero_add, div0
	);

	modport dst (
		input sgn_prod, sgn_a, sgn_b_eff, res_zero_mul, res_zero_add, div0
	);

endinterface

// File: source/exp_unit.sv
module exp_unit import fpm_op_pkg::*, fpm_num_pkg::*; (
	input logic f2strob,
	input logic _0_d_,
	input logic load,
	input fpm_op_t op,
	input logic [EXP_W-1:0] exp_a,
	input logic [EXP_W-1:0] exp_b,
	exp_status_if.src es
);

	logic signed [EXT_W-1:0] a_x;
	logic signed [EXT_W-1:0] b_x;
	fpm_op_t op_q;

	logic [EXT_W-1:0] b_bus;
	logic signed [EXT_W-1:0] sum;
	logic [EXT_W-1:0] mag;
	logic add;
	logic ge_n;
	logic far_n;
	logic [SHIFT_W-1:0] shift_n;
	logic signed [EXT_W-1:0] exp_n;
	logic ovf_n;
	logic unf_n;

	// operands, sign-extended into the guard bits
	always_ff @(posedge f2strob) begin
		if (load) begin
			a_x <= {{(EXT_W-EXP_W){exp_a[EXP_W-1]}}, exp_a};
			b_x <= {{(EXT_W-EXP_W){exp_b[EXP_W-1]}}, exp_b};
			op_q <= op;
		end
	end

	// B bus: ~b plus carry in subtracts, plain b adds
	assign b_bus = b_compl(op_q) ? ~b_x : b_x;
	assign sum = a_x + b_bus + EXT_W'(b_compl(op_q));

	assign add = is_add_class(op_q);
	assign ge_n = ~sum[EXT_W-1];
	assign mag = sum[EXT_W-1] ? -sum : sum;

	// alignment shift saturates at the far point
	assign far_n = (mag >= EXT_W'(FAR_SHIFT));
	assign shift_n = far_n ? SHIFT_W'(FAR_SHIFT) : mag[SHIFT_W-1:0];

	always_comb begin
		if (add) begin
			// result takes the larger exponent
			exp_n = ge_n ? a_x : b_x;
			ovf_n = 1'b0;
			unf_n = 1'b0;
		end else begin
			exp_n = sum;
			ovf_n = (sum > EXP_MAX);
			unf_n = (sum < EXP_MIN);
		end
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			es.ext_exp <= '0;
			es.a_ge_b <= 1'b0;
			es.shift <= '0;
			es.far <= 1'b0;
			es.ovf <= 1'b0;
			es.unf <= 1'b0;
		end else begin
			es.ext_exp <= exp_n;
			es.a_ge_b <= ge_n;
			es.shift <= shift_n;
			es.far <= far_n;
			es.ovf <= ovf_n;
			es.unf <= unf_n;
		end
	end

endmodule

// File: source/sign_unit.sv
module sign_unit import fpm_op_pkg::*; (
	input logic f2strob,
	input logic _0_d_,
	input logic load,
	input fpm_op_t op,
	input logic sgn_a,
	input logic sgn_b,
	input logic zero_a,
	input logic zero_b,
	sgn_status_if.src ss
);

	fpm_op_t op_q;
	logic sa_q;
	logic sb_q;
	logic za_q;
	logic zb_q;
	logic add;

	// mantissa status as presented with the operands
	always_ff @(posedge f2strob) begin
		if (load) begin
			op_q <= op;
			sa_q <= sgn_a;
			sb_q <= sgn_b;
			za_q <= zero_a;
			zb_q <= zero_b;
		end
	end

	assign add = is_add_class(op_q);

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			ss.sgn_prod <= 1'b0;
			ss.sgn_a <= 1'b0;
			ss.sgn_b_eff <= 1'b0;
			ss.res_zero_mul <= 1'b0;
			ss.res_zero_add <= 1'b0;
			ss.div0 <= 1'b0;
		end else begin
			ss.sgn_prod <= sa_q ^ sb_q;
			ss.sgn_a <= sa_q;
			// subtract flips b before the compare
			ss.sgn_b_eff <= sb_q ^ (op_q == OP_SF);
			ss.res_zero_mul <= ~add & za_q;
			ss.res_zero_add <= add & za_q & zb_q;
			ss.div0 <= (op_q == OP_DF) & zb_q;
		end
	end

endmodule

// File: source/fpm_flags.sv
module fpm_flags import fpm_op_pkg::*, fpm_num_pkg::*; (
	input logic f2strob,
	input logic _0_d_,
	input logic commit,
	input fpm_op_t op,
	exp_status_if.dst es,
	sgn_status_if.dst ss,
	output logic [EXP_W-1:0] exp_r,
	output logic [SHIFT_W-1:0] shift_r,
	output logic sgn_r,
	output fpm_flags_t flags,
	output fpm_int_t int_code
);

	logic add;
	logic sgn_n;
	logic zero_n;
	logic [EXP_W-1:0] exp_n;
	logic [SHIFT_W-1:0] shift_n;
	fpm_flags_t flags_n;
	fpm_int_t int_n;

	assign add = is_add_class(op);

	// larger operand's sign for af and sf and the product sign otherwise
	always_comb begin
		if (add) begin
			sgn_n = es.a_ge_b ? ss.sgn_a : ss.sgn_b_eff;
			zero_n = ss.res_zero_add;
		end else begin
			sgn_n = ss.sgn_prod;
			zero_n = ss.res_zero_mul;
		end
	end

	// first matching rule wins
	always_comb begin
		exp_n = es.ext_exp[EXP_W-1:0];
		flags_n = '0;
		flags_n.m = sgn_n;
		int_n = INT_NONE;
		if (ss.div0) begin
			int_n = INT_DIV0;
			exp_n = '0;
			flags_n.z = 1'b1;
		end else if (zero_n) begin
			exp_n = '0;
			flags_n.m = 1'b0;
			flags_n.z = 1'b1;
		end else if (es.ovf || es.unf) begin
			int_n = es.ovf ? INT_OVF : INT_UNF;
			flags_n.v = 1'b1;
		end
		flags_n.c = add & es.far;
	end

	assign shift_n = add ? es.shift : '0;

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			exp_r <= '0;
			shift_r <= '0;
			sgn_r <= 1'b0;
			flags <= '0;
			int_code <= INT_NONE;
		end else if (commit) begin
			exp_r <= exp_n;
			shift_r <= shift_n;
			sgn_r <= flags_n.m;
			flags <= flags_n;
			int_code <= int_n;
		end
	end

endmodule

// File: source/fpm_seq.sv
module fpm_seq (
	input logic f2strob,
	input logic _0_d_,
	input logic req,
	output logic ack,
	output logic load,
	output logic commit
);

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_busy = 2'd1,
		st_done = 2'd2
	} seq_state_t;

	seq_state_t state;

	// operands go in on the edge that first sees req
	assign load = (state == st_idle) & req;
	assign ack = (state == st_done);

	// busy lasts two cycles, commit marks the second
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			state <= st_idle;
			commit <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (req)
						state <= st_busy;
				end
				st_busy: begin
					commit <= ~commit;
					if (commit)
						state <= st_done;
				end
				st_done: begin
					// hold until host lets go
					if (!req)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: source/fpm_top.sv
module fpm_top import fpm_op_pkg::*, fpm_num_pkg::*; (
	input logic f2strob,
	input logic _0_d_,
	input logic req,
	input logic [1:0] op,
	input logic [EXP_W-1:0] exp_a,
	input logic [EXP_W-1:0] exp_b,
	input logic sgn_a,
	input logic sgn_b,
	input logic zero_a,
	input logic zero_b,
	output logic ack,
	output logic [EXP_W-1:0] exp_r,
	output logic [SHIFT_W-1:0] shift_r,
	output logic sgn_r,
	output logic flag_c,
	output logic flag_v,
	output logic flag_m,
	output logic flag_z,
	output logic [1:0] int_code
);

	fpm_op_t op_w;
	logic load;
	logic commit;
	fpm_flags_t flags_w;
	fpm_int_t int_w;

	exp_status_if es ();
	sgn_status_if ss ();

	assign op_w = fpm_op_t'(op);

	fpm_seq u_seq (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.req(req),
		.ack(ack),
		.load(load),
		.commit(commit)
	);

	exp_unit u_exp (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.load(load),
		.op(op_w),
		.exp_a(exp_a),
		.exp_b(exp_b),
		.es(es.src)
	);

	sign_unit u_sgn (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.load(load),
		.op(op_w),
		.sgn_a(sgn_a),
		.sgn_b(sgn_b),
		.zero_a(zero_a),
		.zero_b(zero_b),
		.ss(ss.src)
	);

	fpm_flags u_flags (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.commit(commit),
		.op(op_w),
		.es(es.dst),
		.ss(ss.dst),
		.exp_r(exp_r),
		.shift_r(shift_r),
		.sgn_r(sgn_r),
		.flags(flags_w),
		.int_code(int_w)
	);

	// flag struct out to single pins
	assign flag_c = flags_w.c;
	assign flag_v = flags_w.v;
	assign flag_m = flags_w.m;
	assign flag_z = flags_w.z;
	assign int_code = int_w;

endmodule

// File: verif/fpm_tb.sv
module fpm_tb import fpm_op_pkg::*, fpm_num_pkg::*; ();

	localparam int MAX_PAT = 64;
	localparam int N_RAND = 200;
	localparam int ACK_LIMIT = 10;

	logic f2strob;
	logic _0_d_;
	logic req;
	logic [1:0] op;
	logic [7:0] exp_a;
	logic [7:0] exp_b;
	logic sgn_a;
	logic sgn_b;
	logic zero_a;
	logic zero_b;
	logic ack;
	logic [7:0] exp_r;
	logic [5:0] shift_r;
	logic sgn_r;
	logic flag_c;
	logic flag_v;
	logic flag_m;
	logic flag_z;
	logic [1:0] int_code;
	logic [20:0] out_now;

	logic [51:0] pats [0:MAX_PAT-1];
	logic [31:0] seed;
	int npat;
	int ncase;
	int checks;
	int errors;
	logic loaded;

	fpm_top DUT (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.req(req),
		.op(op),
		.exp_a(exp_a),
		.exp_b(exp_b),
		.sgn_a(sgn_a),
		.sgn_b(sgn_b),
		.zero_a(zero_a),
		.zero_b(zero_b),
		.ack(ack),
		.exp_r(exp_r),
		.shift_r(shift_r),
		.sgn_r(sgn_r),
		.flag_c(flag_c),
		.flag_v(flag_v),
		.flag_m(flag_m),
		.flag_z(flag_z),
		.int_code(int_code)
	);

	// exp_r, shift_r, sgn_r, c, v, m, z, int_code
	assign out_now = {exp_r, shift_r, sgn_r, flag_c, flag_v, flag_m, flag_z, int_code};

	always #50 f2strob = ~f2strob;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// expected outputs packed like out_now
	function automatic logic [20:0] model_result(input logic [1:0] o, input logic [7:0] ea,
			input logic [7:0] eb, input logic [3:0] sz);
		int a;
		int b;
		int r;
		int mag;
		logic sa;
		logic sb;
		logic za;
		logic zb;
		logic add;
		logic ge;
		logic far;
		logic sgn;
		logic zero;
		logic v;
		logic z;
		logic [7:0] er;
		logic [5:0] sh;
		logic [1:0] ic;
		a = $signed(ea);
		b = $signed(eb);
		{sa, sb, za, zb} = sz;
		add = (o == OP_AF) || (o == OP_SF);
		r = (o == OP_MF) ? a + b : a - b;
		mag = (r < 0) ? -r : r;
		ge = (r >= 0);
		far = add && (mag >= 40);
		sh = !add ? 6'd0 : (mag >= 40) ? 6'd40 : 6'(mag);
		if (add) begin
			r = ge ? a : b;
			sgn = ge ? sa : (sb ^ (o == OP_SF));
			zero = za & zb;
		end else begin
			sgn = sa ^ sb;
			zero = za;
		end
		er = 8'(r);
		v = 1'b0;
		z = 1'b0;
		ic = INT_NONE;
		if (o == OP_DF && zb) begin
			ic = INT_DIV0;
			er = 8'd0;
			z = 1'b1;
		end else if (zero) begin
			er = 8'd0;
			sgn = 1'b0;
			z = 1'b1;
		end else if (!add && r > 127) begin
			ic = INT_OVF;
			v = 1'b1;
		end else if (!add && r < -128) begin
			ic = INT_UNF;
			v = 1'b1;
		end
		return {er, sh, sgn, far, v, sgn, z, ic};
	endfunction

	task automatic check_value(input string name, input logic [7:0] expv, input logic [7:0] got);
		checks = checks + 1;
		if (got !== expv) begin
			errors = errors + 1;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, expv, got);
		end
	endtask

	task automatic compare_outputs(input logic [20:0] expv);
		check_value("exp_r", expv[20:13], exp_r);
		check_value("shift_r", 8'(expv[12:7]), 8'(shift_r));
		check_value("sgn_r", 8'(expv[6]), 8'(sgn_r));
		check_value("flag_c", 8'(expv[5]), 8'(flag_c));
		check_value("flag_v", 8'(expv[4]), 8'(flag_v));
		check_value("flag_m", 8'(expv[3]), 8'(flag_m));
		check_value("flag_z", 8'(expv[2]), 8'(flag_z));
		check_value("int_code", 8'(expv[1:0]), 8'(int_code));
	endtask

	// one full four-phase handshake with req held for hold extra cycles
	task automatic run_case(input logic [1:0] c_op, input logic [7:0] c_ea,
			input logic [7:0] c_eb, input logic [3:0] c_sz, input logic [20:0] expv,
			input int hold);
		int n;
		logic [20:0] held;
		@(posedge f2strob);
		op <= c_op;
		exp_a <= c_ea;
		exp_b <= c_eb;
		{sgn_a, sgn_b, zero_a, zero_b} <= c_sz;
		req <= 1'b1;
		// edge N samples req
		@(posedge f2strob);
		@(negedge f2strob);
		n = 0;
		while (!ack && n < ACK_LIMIT) begin
			@(negedge f2strob);
			n = n + 1;
		end
		ncase = ncase + 1;
		if (!ack) begin
			errors = errors + 1;
			$display("case %0d: ack never arrived after req was raised", ncase);
		end else begin
			checks = checks + 1;
			if (n != 2) begin
				errors = errors + 1;
				$display("[ERROR] %0t ack_latency expected 2 got %0d", $time, n);
			end
			compare_outputs(expv);
			held = out_now;
			repeat (hold) begin
				@(negedge f2strob);
				checks = checks + 1;
				if (!ack) begin
					errors = errors + 1;
					$display("case %0d: ack dropped while req was still high", ncase);
				end
				if (out_now !== held) begin
					errors = errors + 1;
					$display("[ERROR] %0t outputs expected %h got %h", $time, held, out_now);
				end
			end
		end
		@(posedge f2strob);
		req <= 1'b0;
		@(posedge f2strob);
		@(negedge f2strob);
		n = 0;
		while (ack && n < ACK_LIMIT) begin
			@(negedge f2strob);
			n = n + 1;
		end
		checks = checks + 1;
		if (ack) begin
			errors = errors + 1;
			$display("case %0d: ack never fell after req was dropped", ncase);
		end else if (n != 0) begin
			errors = errors + 1;
			$display("case %0d: ack fell %0d cycles late", ncase, n);
		end
	endtask

	initial begin
		wait (loaded);
		#((npat + N_RAND) * 20 * 100 + 5 * 100);
		$display("watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int i;
		int e0;
		logic [51:0] p;
		logic [1:0] r_op;
		logic [7:0] r_ea;
		logic [7:0] r_eb;
		logic [3:0] r_sz;
		f2strob = 1'b0;
		_0_d_ = 1'b0;
		req = 1'b0;
		op = 2'd0;
		exp_a = 8'd0;
		exp_b = 8'd0;
		{sgn_a, sgn_b, zero_a, zero_b} = 4'd0;
		seed = 32'd84726;
		ncase = 0;
		checks = 0;
		errors = 0;
		loaded = 1'b0;
		$readmemh("verif/fpm_patterns.txt", pats);
		npat = 0;
		while (npat < MAX_PAT && !$isunknown(pats[npat]) && pats[npat] !== '1)
			npat = npat + 1;
		loaded = 1'b1;
		repeat (5) @(posedge f2strob);
		_0_d_ <= 1'b1;

		@(negedge f2strob);
		e0 = errors;
		check_value("ack", 8'd0, 8'(ack));
		compare_outputs('0);
		$display("test reset_values: %0d errors", errors - e0);

		e0 = errors;
		if (npat == 0) begin
			errors = errors + 1;
			$display("pattern file gave no cases");
		end
		for (i = 0; i < npat; i++) begin
			p = pats[i];
			run_case(p[49:48], p[47:40], p[39:32], p[31:28],
				{p[27:20], p[17:12], p[8], p[7:4], p[1:0]}, i % 3);
		end
		$display("test directed_patterns: %0d cases, %0d errors", npat, errors - e0);

		e0 = errors;
		for (i = 0; i < N_RAND; i++) begin
			seed = lcg_next(seed);
			r_op = seed[31:30];
			r_ea = seed[29:22];
			r_eb = seed[21:14];
			seed = lcg_next(seed);
			// zero mantissas one time in eight
			r_sz = {seed[31], seed[30], seed[29:27] == 3'd0, seed[26:24] == 3'd0};
			run_case(r_op, r_ea, r_eb, r_sz, model_result(r_op, r_ea, r_eb, r_sz),
				int'(seed[23:22]));
		end
		$display("test random_cases: %0d cases, %0d errors", N_RAND, errors - e0);

		$display("%0d cases, %0d checks, %0d errors", ncase, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: flist.f
source/fpm_op_pkg.sv
source/fpm_num_pkg.sv
source/fpm_if.sv
source/exp_unit.sv
source/sign_unit.sv
source/fpm_flags.sv
source/fpm_seq.sv
source/fpm_top.sv
verif/fpm_tb.sv

// File: Makefile
TOP = fpm_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f -o $(TOP)_sim

run: build
	./obj_dir/$(TOP)_sim > run.log 2>&1; cat run.log
	grep -qF "*** TEST PASSED ***" run.log

lint:
	verilator --lint-only -Wall --top-module fpm_top \
		source/fpm_op_pkg.sv source/fpm_num_pkg.sv source/fpm_if.sv \
		source/exp_unit.sv source/sign_unit.sv source/fpm_flags.sv \
		source/fpm_seq.sv source/fpm_top.sv

clean:
	rm -rf obj_dir run.log

// File: verif/fpm_patterns.txt
// fields op exp_a exp_b {sgn_a sgn_b zero_a zero_b} exp_r shift_r sgn_r {c v m z} int_code
// a line of all ones ends the list
0_0a_03_0_0a_07_0_0_0
0_03_0a_4_0a_07_1_2_0
1_03_0a_4_0a_07_0_0_0
1_0a_03_8_0a_07_1_2_0
0_14_14_4_14_00_0_0_0
0_28_00_0_28_28_0_8_0
0_27_00_0_27_27_0_0_0
0_00_29_0_29_28_0_8_0
1_80_7f_0_7f_28_1_a_0
0_7f_80_c_7f_28_1_a_0
0_fb_ec_0_fb_0f_0_0_0
1_ec_fb_0_fb_0f_1_2_0
0_05_02_3_00_03_0_1_0
0_05_02_2_05_03_0_0_0
1_3c_00_f_00_28_0_9_0
1_01_04_1_04_03_1_2_0
2_0a_14_0_1e_00_0_0_0
2_0a_14_8_1e_00_1_2_0
2_f6_03_c_f9_00_0_0_0
2_64_1b_0_7f_00_0_0_0
2_64_1c_0_80_00_0_4_1
2_7f_7f_8_fe_00_1_6_1
2_9c_e4_0_80_00_0_0_0
2_9c_e3_0_7f_00_0_4_2
2_80_80_4_00_00_1_6_2
2_64_1c_2_00_00_0_1_0
2_03_04_1_07_00_0_0_0
3_14_05_4_0f_00_1_2_0
3_05_14_0_f1_00_0_0_0
3_7f_ff_0_80_00_0_4_1
3_80_01_c_7f_00_0_4_2
3_80_7f_0_01_00_0_4_2
3_0a_03_1_00_00_0_1_3
3_0a_03_9_00_00_1_3_3
3_0a_03_3_00_00_0_1_3
3_7f_ff_a_00_00_0_1_0
3_7f_ff_1_00_00_0_1_3
f_ff_ff_f_ff_ff_f_f_f
